// File: design/maze_geom_pkg.sv
// maze geometry package with grid size, coordinate types and cell codes
package maze_geom_pkg;

	localparam int GRID_DIM = 16;
	localparam int COORD_W  = $clog2(GRID_DIM);
	localparam int COST_W   = 8;

	typedef logic [COORD_W-1:0]  coord_t;
	typedef logic [GRID_DIM-1:0] row_bits_t; // bit i is column i
	typedef logic [COST_W-1:0]   cost_t;

	// upper bit set means the wave has reached the cell
	typedef enum logic [1:0] {
		CELL_EMPTY   = 2'd0,
		CELL_BLOCKED = 2'd1, // obstacle, also used for route marks
		CELL_WAVE_LO = 2'd2,
		CELL_WAVE_HI = 2'd3
	} cell_t;

endpackage

// File: design/router_ctrl_pkg.sv
// router control package with FSM states, grid commands and wave phase width
package router_ctrl_pkg;

	localparam int PHASE_W = 2; // top bit gives the low bit of the wave code

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SEED,
		ST_WAVE,
		ST_RETRACE,
		ST_CLEAR,
		ST_DONE
	} state_t;

	typedef enum logic [2:0] {
		OP_HOLD,
		OP_LOAD,
		OP_SEED,
		OP_WAVE,
		OP_MARK,
		OP_CLEAR
	} grid_op_t;

endpackage

// File: design/grid_if.sv
// grid access link between the cell array and the retrace walker
`timescale 1ns/1ps

interface grid_if;
	import maze_geom_pkg::*;

	coord_t pos_x;     // walker position
	coord_t pos_y;
	cell_t  want_code; // predecessor code the walker looks for
	cell_t  nb_down;
	cell_t  nb_up;
	cell_t  nb_right;
	cell_t  nb_left;
	logic   mark_en;

	modport grid (
		input  pos_x, pos_y, mark_en,
		output nb_down, nb_up, nb_right, nb_left
	);

	modport walker (
		output pos_x, pos_y, want_code, mark_en,
		input  nb_down, nb_up, nb_right, nb_left
	);

endinterface

// File: design/net_loader.sv
// net loader that counts obstacle rows and latches the net endpoints
`timescale 1ns/1ps

module net_loader (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  maze_geom_pkg::row_bits_t row_bits,
	input  maze_geom_pkg::coord_t    src_x,
	input  maze_geom_pkg::coord_t    src_y,
	input  maze_geom_pkg::coord_t    snk_x,
	input  maze_geom_pkg::coord_t    snk_y,
	output logic                     row_we,
	output maze_geom_pkg::coord_t    row_idx,
	output maze_geom_pkg::row_bits_t row_data,
	output maze_geom_pkg::coord_t    src_x_q,
	output maze_geom_pkg::coord_t    src_y_q,
	output maze_geom_pkg::coord_t    snk_x_q,
	output maze_geom_pkg::coord_t    snk_y_q,
	output logic                     load_last
);
	import maze_geom_pkg::*;

	coord_t row_cnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			row_cnt <= '0;
			row_we  <= 1'b0;
		end
		else
		begin
			row_cnt <= in_valid ? coord_t'(row_cnt + 1'b1) : '0;
			row_we  <= in_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		row_idx  <= row_cnt;
		row_data <= row_bits;
		if (in_valid && row_cnt == '0) // endpoints come with row 0
		begin
			src_x_q <= src_x;
			src_y_q <= src_y;
			snk_x_q <= snk_x;
			snk_y_q <= snk_y;
		end
	end

	assign load_last = row_we && (row_idx == coord_t'(GRID_DIM - 1));

endmodule

// File: design/grid_array.sv
// cell state array with load, seed, wave expansion, route mark and clear
`timescale 1ns/1ps

module grid_array (
	input  logic                       clk,
	input  logic                       rst_n,
	input  router_ctrl_pkg::grid_op_t  grid_op,
	input  logic                       phase,
	input  logic                       row_we,
	input  maze_geom_pkg::coord_t      row_idx,
	input  maze_geom_pkg::row_bits_t   row_data,
	input  maze_geom_pkg::coord_t      src_x_q,
	input  maze_geom_pkg::coord_t      src_y_q,
	input  maze_geom_pkg::coord_t      snk_x_q,
	input  maze_geom_pkg::coord_t      snk_y_q,
	output logic                       sink_hit,
	output logic                       front_stalled,
	grid_if.grid                       gif
);
	import maze_geom_pkg::*;
	import router_ctrl_pkg::*;

	cell_t cells [GRID_DIM][GRID_DIM]; // indexed [y][x]

	logic [GRID_DIM+1:0][GRID_DIM+1:0] reach_pad; // reached flags with a zero border
	logic [GRID_DIM-1:0][GRID_DIM-1:0] grow;
	logic [GRID_DIM-1:0][GRID_DIM-1:0] blk_map;
	cell_t  wave_code;
	coord_t y_dn, y_up, x_rt, x_lf;

	assign wave_code = phase ? CELL_WAVE_HI : CELL_WAVE_LO;

	// ------------------------------
	// wavefront
	// ------------------------------
	always_comb
	begin
		reach_pad = '0;
		for (int y = 0; y < GRID_DIM; y++)
			for (int x = 0; x < GRID_DIM; x++)
				reach_pad[y+1][x+1] = cells[y][x][1];
		for (int y = 0; y < GRID_DIM; y++)
			for (int x = 0; x < GRID_DIM; x++)
			begin
				grow[y][x] = (cells[y][x] == CELL_EMPTY) &&
					(reach_pad[y][x+1] || reach_pad[y+2][x+1] ||
					 reach_pad[y+1][x] || reach_pad[y+1][x+2]);
				blk_map[y][x] = (cells[y][x] == CELL_BLOCKED);
			end
	end

	assign sink_hit      = cells[snk_y_q][snk_x_q][1];
	assign front_stalled = (grid_op == OP_WAVE) && !(|grow); // nothing changed this cycle

	always_ff @(posedge clk)
	begin
		case (grid_op)
			OP_LOAD:
				if (row_we)
					for (int x = 0; x < GRID_DIM; x++)
						cells[row_idx][x] <= row_data[x] ? CELL_BLOCKED : CELL_EMPTY;
			OP_SEED:
			begin
				cells[src_y_q][src_x_q] <= CELL_WAVE_HI;
				cells[snk_y_q][snk_x_q] <= CELL_EMPTY;
			end
			OP_WAVE:
				for (int y = 0; y < GRID_DIM; y++)
					for (int x = 0; x < GRID_DIM; x++)
						if (grow[y][x])
							cells[y][x] <= wave_code;
			OP_MARK:
				if (gif.mark_en)
					cells[gif.pos_y][gif.pos_x] <= CELL_BLOCKED; // route mark
			OP_CLEAR:
				for (int y = 0; y < GRID_DIM; y++)
					for (int x = 0; x < GRID_DIM; x++)
						if (cells[y][x][1])
							cells[y][x] <= CELL_EMPTY;
			default: ;
		endcase
	end

	// ------------------------------
	// neighbor read for the walker
	// ------------------------------
	assign y_dn = gif.pos_y + 1'b1;
	assign y_up = gif.pos_y - 1'b1;
	assign x_rt = gif.pos_x + 1'b1;
	assign x_lf = gif.pos_x - 1'b1;

	// off-grid neighbors read as blocked
	assign gif.nb_down  = (gif.pos_y != coord_t'(GRID_DIM - 1)) ? cells[y_dn][gif.pos_x] : CELL_BLOCKED;
	assign gif.nb_up    = (gif.pos_y != '0) ? cells[y_up][gif.pos_x] : CELL_BLOCKED;
	assign gif.nb_right = (gif.pos_x != coord_t'(GRID_DIM - 1)) ? cells[gif.pos_y][x_rt] : CELL_BLOCKED;
	assign gif.nb_left  = (gif.pos_x != '0) ? cells[gif.pos_y][x_lf] : CELL_BLOCKED;

	a_blocked_stable: assert property (@(posedge clk) disable iff (!rst_n)
		grid_op == OP_WAVE |=> (blk_map & $past(blk_map)) == $past(blk_map));

endmodule

// File: design/retrace_unit.sv
// retrace walker that steps from sink to source and streams the route
`timescale 1ns/1ps

module retrace_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  retrace_start,
	input  logic                  retrace_en,
	input  logic                  phase,
	input  maze_geom_pkg::coord_t src_x_q,
	input  maze_geom_pkg::coord_t src_y_q,
	input  maze_geom_pkg::coord_t snk_x_q,
	input  maze_geom_pkg::coord_t snk_y_q,
	output logic                  route_valid,
	output maze_geom_pkg::coord_t route_x,
	output maze_geom_pkg::coord_t route_y,
	output maze_geom_pkg::cost_t  cost,
	output logic                  at_source,
	grid_if.walker                gif
);
	import maze_geom_pkg::*;

	coord_t nxt_x, nxt_y;
	logic   step;

	assign gif.want_code = phase ? CELL_WAVE_HI : CELL_WAVE_LO; // predecessor code
	assign gif.mark_en   = retrace_en;
	assign at_source     = (gif.pos_x == src_x_q) && (gif.pos_y == src_y_q);
	assign step          = retrace_en && !at_source;

	// fixed priority down, up, right, left
	always_comb
	begin
		nxt_x = gif.pos_x;
		nxt_y = gif.pos_y;
		if (gif.nb_down == gif.want_code)
			nxt_y = gif.pos_y + 1'b1;
		else if (gif.nb_up == gif.want_code)
			nxt_y = gif.pos_y - 1'b1;
		else if (gif.nb_right == gif.want_code)
			nxt_x = gif.pos_x + 1'b1;
		else if (gif.nb_left == gif.want_code)
			nxt_x = gif.pos_x - 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			gif.pos_x   <= '0;
			gif.pos_y   <= '0;
			cost        <= '0;
			route_valid <= 1'b0;
		end
		else
		begin
			route_valid <= retrace_en;
			if (retrace_start)
			begin
				gif.pos_x <= snk_x_q; // walk starts at the sink
				gif.pos_y <= snk_y_q;
				cost      <= '0;
			end
			else if (step)
			begin
				gif.pos_x <= nxt_x;
				gif.pos_y <= nxt_y;
				cost      <= cost + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		route_x <= gif.pos_x;
		route_y <= gif.pos_y;
	end

	a_single_step: assert property (@(posedge clk) disable iff (!rst_n)
		step |=>
		((gif.pos_y == $past(gif.pos_y)) &&
		 (coord_t'(gif.pos_x - $past(gif.pos_x)) inside {coord_t'(1), '1})) ||
		((gif.pos_x == $past(gif.pos_x)) &&
		 (coord_t'(gif.pos_y - $past(gif.pos_y)) inside {coord_t'(1), '1})));

endmodule

// File: design/router_ctrl.sv
// router FSM with 2-2-3-3 phase counter, busy, done and no-route flags
`timescale 1ns/1ps

module router_ctrl (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      in_valid,
	input  logic                      load_last,
	input  logic                      sink_hit,
	input  logic                      front_stalled,
	input  logic                      at_source,
	output router_ctrl_pkg::grid_op_t grid_op,
	output logic                      phase,
	output logic                      retrace_start,
	output logic                      retrace_en,
	output logic                      busy,
	output logic                      done,
	output logic                      no_route
);
	import router_ctrl_pkg::*;

	state_t             state, state_nxt;
	logic [PHASE_W-1:0] phase_cnt;

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:    if (in_valid) state_nxt = ST_LOAD;
			ST_LOAD:    if (load_last) state_nxt = ST_SEED;
			ST_SEED:    state_nxt = ST_WAVE;
			ST_WAVE:
			begin
				if (sink_hit)
					state_nxt = ST_RETRACE;
				else if (front_stalled)
					state_nxt = ST_CLEAR; // no route, skip retrace
			end
			ST_RETRACE: if (at_source) state_nxt = ST_CLEAR;
			ST_CLEAR:   state_nxt = ST_DONE;
			default:    state_nxt = ST_IDLE;
		endcase
	end

	always_comb
	begin
		case (state)
			ST_LOAD:    grid_op = OP_LOAD;
			ST_SEED:    grid_op = OP_SEED;
			ST_WAVE:    grid_op = OP_WAVE;
			ST_RETRACE: grid_op = OP_MARK;
			ST_CLEAR:   grid_op = OP_CLEAR;
			default:    grid_op = OP_HOLD;
		endcase
	end

	assign phase         = phase_cnt[PHASE_W-1];
	assign retrace_start = (state == ST_SEED); // also clears cost for a blocked net
	assign retrace_en    = (state == ST_RETRACE);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= ST_IDLE;
			phase_cnt <= '0;
			busy      <= 1'b0;
			done      <= 1'b0;
			no_route  <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			done  <= (state == ST_CLEAR);
			case (state)
				ST_WAVE:    phase_cnt <= sink_hit ? phase_cnt - 2'd2 : phase_cnt + 1'b1;
				ST_RETRACE: phase_cnt <= phase_cnt - 1'b1; // walk the codes backwards
				default:    phase_cnt <= '0;
			endcase
			if (state == ST_IDLE && in_valid)
			begin
				busy     <= 1'b1;
				no_route <= 1'b0;
			end
			else if (state == ST_CLEAR)
				busy <= 1'b0; // low in the done cycle
			if (state == ST_WAVE && !sink_hit && front_stalled)
				no_route <= 1'b1;
		end
	end

	a_done_not_retrace: assert property (@(posedge clk) disable iff (!rst_n)
		!(done && retrace_en));

endmodule

// File: design/maze_router.sv
// maze router top joining loader, cell array, retrace walker and FSM
`timescale 1ns/1ps

module maze_router (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  maze_geom_pkg::row_bits_t row_bits,
	input  maze_geom_pkg::coord_t    src_x,
	input  maze_geom_pkg::coord_t    src_y,
	input  maze_geom_pkg::coord_t    snk_x,
	input  maze_geom_pkg::coord_t    snk_y,
	output logic                     busy,
	output logic                     route_valid,
	output maze_geom_pkg::coord_t    route_x,
	output maze_geom_pkg::coord_t    route_y,
	output maze_geom_pkg::cost_t     cost,
	output logic                     no_route,
	output logic                     done
);
	import maze_geom_pkg::*;
	import router_ctrl_pkg::*;

	logic      row_we, load_last;
	coord_t    row_idx;
	row_bits_t row_data;
	coord_t    src_x_q, src_y_q, snk_x_q, snk_y_q;
	grid_op_t  grid_op;
	logic      phase, retrace_start, retrace_en;
	logic      sink_hit, front_stalled, at_source;

	grid_if gif ();

	net_loader u_loader (
		.clk, .rst_n, .in_valid, .row_bits, .src_x, .src_y, .snk_x, .snk_y,
		.row_we, .row_idx, .row_data, .src_x_q, .src_y_q, .snk_x_q, .snk_y_q, .load_last
	);

	grid_array u_grid (
		.clk, .rst_n, .grid_op, .phase, .row_we, .row_idx, .row_data,
		.src_x_q, .src_y_q, .snk_x_q, .snk_y_q, .sink_hit, .front_stalled,
		.gif(gif.grid)
	);

	retrace_unit u_retrace (
		.clk, .rst_n, .retrace_start, .retrace_en, .phase,
		.src_x_q, .src_y_q, .snk_x_q, .snk_y_q,
		.route_valid, .route_x, .route_y, .cost, .at_source,
		.gif(gif.walker)
	);

	router_ctrl u_ctrl (
		.clk, .rst_n, .in_valid, .load_last, .sink_hit, .front_stalled, .at_source,
		.grid_op, .phase, .retrace_start, .retrace_en, .busy, .done, .no_route
	);

endmodule

// File: tb/route_checker.sv
// route checker that watches the router ports and compares each result with the reference
`timescale 1ns/1ps

module route_checker (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  logic                  busy,
	input  logic                  route_valid,
	input  maze_geom_pkg::coord_t route_x,
	input  maze_geom_pkg::coord_t route_y,
	input  maze_geom_pkg::cost_t  cost,
	input  logic                  no_route,
	input  logic                  done,
	input  logic [maze_geom_pkg::GRID_DIM-1:0][maze_geom_pkg::GRID_DIM-1:0] obst,
	input  maze_geom_pkg::coord_t src_x,
	input  maze_geom_pkg::coord_t src_y,
	input  maze_geom_pkg::coord_t snk_x,
	input  maze_geom_pkg::coord_t snk_y,
	input  int                    exp_dist, // -1 when the sink cannot be reached
	input  int                    test_id,
	output int                    err_cnt
);
	import maze_geom_pkg::*;

	coord_t rx [$]; // route cells in arrival order
	coord_t ry [$];
	logic [GRID_DIM-1:0][GRID_DIM-1:0] seen;
	bit tracking = 1'b0;
	bit rst_seen = 1'b0;
	int test_err = 0;
	int err_total = 0;

	assign err_cnt = err_total;

	task automatic bad_value(input string sig, input int got, input int want);
		$display("FAIL t=%0t %s got %0d expected %0d", $time, sig, got, want);
		test_err++;
		err_total++;
	endtask

	task automatic bad_route(input string what);
		$display("ERROR t=%0t test %0d: %s", $time, test_id, what);
		test_err++;
		err_total++;
	endtask

	// ------------------------------
	// result of one net
	// ------------------------------
	task automatic check_result();
		int n;
		int dx;
		int dy;
		n = rx.size();
		if (exp_dist < 0)
		begin
			if (no_route !== 1'b1)
				bad_value("no_route", int'(no_route), 1);
			if (cost !== '0)
				bad_value("cost", int'(cost), 0);
			if (n != 0)
				bad_value("route_valid pulses", n, 0);
		end
		else
		begin
			if (no_route !== 1'b0)
				bad_value("no_route", int'(no_route), 0);
			if (cost !== cost_t'(exp_dist))
				bad_value("cost", int'(cost), exp_dist);
			if (n != exp_dist + 1)
				bad_value("route_valid pulses", n, exp_dist + 1);
			if (n > 0 && (rx[0] != snk_x || ry[0] != snk_y))
				bad_route("route does not start at the sink");
			if (n > 0 && (rx[n-1] != src_x || ry[n-1] != src_y))
				bad_route("route does not end at the source");
			seen = '0;
			for (int i = 0; i < n; i++)
			begin
				if (obst[ry[i]][rx[i]])
					bad_route($sformatf("route cell (%0d,%0d) is an obstacle", rx[i], ry[i]));
				if (seen[ry[i]][rx[i]])
					bad_route($sformatf("route cell (%0d,%0d) repeats", rx[i], ry[i]));
				seen[ry[i]][rx[i]] = 1'b1;
				if (i > 0)
				begin
					dx = int'(rx[i]) - int'(rx[i-1]);
					dy = int'(ry[i]) - int'(ry[i-1]);
					if (dx * dx + dy * dy != 1)
						bad_route($sformatf("route cell (%0d,%0d) is not next to the one before",
							rx[i], ry[i]));
				end
			end
		end
		$display("test %0d: %0s cost=%0d no_route=%0b cells=%0d errors=%0d", test_id,
			(test_err == 0) ? "ok" : "bad", cost, no_route, n, test_err);
		test_err = 0;
		rx.delete();
		ry.delete();
	endtask

	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (!rst_seen) // first edge out of reset
			begin
				if (busy !== 1'b0) bad_value("busy", int'(busy), 0);
				if (done !== 1'b0) bad_value("done", int'(done), 0);
				if (route_valid !== 1'b0) bad_value("route_valid", int'(route_valid), 0);
				if (no_route !== 1'b0) bad_value("no_route", int'(no_route), 0);
				if (cost !== '0) bad_value("cost", int'(cost), 0);
				rst_seen = 1'b1;
			end
			if (tracking && !done && busy !== 1'b1)
				bad_route("busy went low before done");
			if (done && busy !== 1'b0)
				bad_value("busy", int'(busy), 0);
			if (in_valid)
				tracking = 1'b1;
			if (route_valid)
			begin
				rx.push_back(route_x);
				ry.push_back(route_y);
			end
			if (done)
			begin
				check_result();
				tracking = 1'b0;
			end
		end
	end

endmodule

// File: tb/tb_maze_router.sv
// testbench for the maze router with a case table, BFS reference and result checker
`timescale 1ns/1ps

module tb_maze_router;
	import maze_geom_pkg::*;

	localparam int N_CASES     = 9;
	localparam int WAIT_LIMIT  = 3000; // cycles per wait
	localparam int PAT_EMPTY   = 0;
	localparam int PAT_RANDOM  = 1;
	localparam int PAT_WALL    = 2; // full column at x = 8
	localparam int OUT_ROUTE   = 0;
	localparam int OUT_BLOCKED = 1;
	localparam int OUT_ANY     = 2; // reference model decides

	typedef struct packed {
		int pat;
		int sx;
		int sy;
		int tx;
		int ty;
		int outcome;
	} case_t;

	// pattern, source x/y, sink x/y, expected outcome
	localparam case_t CASES [N_CASES] = '{
		'{PAT_EMPTY,   0,  0, 15, 15, OUT_ROUTE},
		'{PAT_EMPTY,   3,  7, 12,  2, OUT_ROUTE},
		'{PAT_RANDOM,  1,  1, 14, 13, OUT_ANY},
		'{PAT_WALL,    2,  5, 13,  9, OUT_BLOCKED},
		'{PAT_RANDOM,  0, 15, 15,  0, OUT_ANY},
		'{PAT_EMPTY,   8,  8,  8,  9, OUT_ROUTE},
		'{PAT_RANDOM,  5,  0, 10, 15, OUT_ANY},
		'{PAT_WALL,   15,  0,  0, 15, OUT_BLOCKED},
		'{PAT_EMPTY,  15, 15,  0,  0, OUT_ROUTE}
	};

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	row_bits_t row_bits;
	coord_t    src_x, src_y, snk_x, snk_y;
	logic      busy, route_valid, no_route, done;
	coord_t    route_x, route_y;
	cost_t     cost;
	logic [GRID_DIM-1:0][GRID_DIM-1:0] obst; // [y][x]
	int        exp_dist;
	int        test_id;
	int        err_cnt;
	int        setup_err;
	int        tests_run;
	bit        timed_out;

	maze_router dut_i (
		.clk, .rst_n, .in_valid, .row_bits, .src_x, .src_y, .snk_x, .snk_y,
		.busy, .route_valid, .route_x, .route_y, .cost, .no_route, .done
	);

	route_checker checker_i (
		.clk, .rst_n, .in_valid, .busy, .route_valid, .route_x, .route_y, .cost,
		.no_route, .done, .obst, .src_x, .src_y, .snk_x, .snk_y, .exp_dist, .test_id,
		.err_cnt
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// shortest path length by breadth-first search, -1 if unreachable
	function automatic int bfs_dist(input logic [GRID_DIM-1:0][GRID_DIM-1:0] m,
		input int sx, input int sy, input int tx, input int ty);
		int d [GRID_DIM][GRID_DIM];
		int q [$];
		int c, x, y, nx, ny;
		int dxs [4] = '{0, 0, 1, -1};
		int dys [4] = '{1, -1, 0, 0};
		foreach (d[i, j])
			d[i][j] = -1;
		d[sy][sx] = 0;
		q.push_back(sy * GRID_DIM + sx);
		while (q.size() > 0)
		begin
			c = q.pop_front();
			y = c / GRID_DIM;
			x = c % GRID_DIM;
			for (int k = 0; k < 4; k++)
			begin
				nx = x + dxs[k];
				ny = y + dys[k];
				if (nx >= 0 && nx < GRID_DIM && ny >= 0 && ny < GRID_DIM)
					if (!m[ny][nx] && d[ny][nx] < 0)
					begin
						d[ny][nx] = d[y][x] + 1;
						q.push_back(ny * GRID_DIM + nx);
					end
			end
		end
		return d[ty][tx];
	endfunction

	task automatic build_case(input int i);
		case_t c;
		c = CASES[i];
		test_id = i;
		obst = '0;
		if (c.pat == PAT_RANDOM)
			for (int y = 0; y < GRID_DIM; y++)
				for (int x = 0; x < GRID_DIM; x++)
					obst[y][x] = ($urandom % 4) == 0; // about one cell in four
		else if (c.pat == PAT_WALL)
			for (int y = 0; y < GRID_DIM; y++)
				obst[y][GRID_DIM/2] = 1'b1;
		obst[c.sy][c.sx] = 1'b0;
		obst[c.ty][c.tx] = 1'b0;
		exp_dist = bfs_dist(obst, c.sx, c.sy, c.tx, c.ty);
		if (c.outcome != OUT_ANY && ((exp_dist < 0) != (c.outcome == OUT_BLOCKED)))
		begin
			$display("setup error: reference route of case %0d does not match the table", i);
			setup_err++;
		end
	endtask

	task automatic send_case(input case_t c);
		@(posedge clk);
		src_x <= coord_t'(c.sx);
		src_y <= coord_t'(c.sy);
		snk_x <= coord_t'(c.tx);
		snk_y <= coord_t'(c.ty);
		for (int r = 0; r < GRID_DIM; r++)
		begin
			in_valid <= 1'b1;
			row_bits <= obst[r];
			@(posedge clk);
		end
		in_valid <= 1'b0;
	endtask

	task automatic wait_idle(output bit ok);
		ok = !busy && !done;
		for (int n = 0; n < WAIT_LIMIT && !ok; n++)
		begin
			@(negedge clk);
			ok = !busy && !done;
		end
		if (!ok)
			$display("timeout: router stayed busy before case %0d", test_id);
	endtask

	task automatic wait_done(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < WAIT_LIMIT && !ok; n++)
		begin
			@(negedge clk);
			ok = done;
		end
		if (!ok)
			$display("timeout: done never came for case %0d", test_id);
		@(posedge clk); // checker takes the result on this edge
		@(negedge clk);
	endtask

	initial
	begin
		bit ok;
		void'($urandom(32'h4a561085));
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		row_bits  = '0;
		src_x     = '0;
		src_y     = '0;
		snk_x     = '0;
		snk_y     = '0;
		obst      = '0;
		exp_dist  = 0;
		test_id   = 0;
		setup_err = 0;
		tests_run = 0;
		timed_out = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		for (int i = 0; i < N_CASES && !timed_out; i++)
		begin
			build_case(i);
			wait_idle(ok);
			if (ok)
			begin
				send_case(CASES[i]);
				wait_done(ok);
			end
			timed_out = !ok;
			if (ok)
				tests_run++;
		end
		$display("tests %0d of %0d, checker errors %0d, setup errors %0d, timeout %0b",
			tests_run, N_CASES, err_cnt, setup_err, timed_out);
		if (!timed_out && err_cnt == 0 && setup_err == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: project.f
design/maze_geom_pkg.sv
design/router_ctrl_pkg.sv
design/grid_if.sv
design/net_loader.sv
design/grid_array.sv
design/retrace_unit.sv
design/router_ctrl.sv
design/maze_router.sv
tb/route_checker.sv
tb/tb_maze_router.sv

// File: Makefile
# Verilator build and run for the maze router testbench

VERILATOR ?= verilator
TOP       ?= tb_maze_router
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
